// ==== osc_pkg.sv ====
`default_nettype none

package osc_pkg;

  // s1.16 fixed point
  typedef logic signed [17:0] fx_t;

  typedef struct packed {
    fx_t k1;
    fx_t kmid;
    fx_t k2;
    fx_t g1;   // damping on v1
    fx_t g2;   // damping on v2
  } osc_coeff_t;

  typedef struct packed {
    fx_t x1;
    fx_t v1;
    fx_t x2;
    fx_t v2;
  } osc_state_t;

  // host load word
  typedef struct packed {
    osc_coeff_t coeff;
    osc_state_t init;
  } osc_cfg_t;

  typedef struct packed {
    fx_t a1;
    fx_t a2;
  } osc_accel_t;

  typedef enum logic {
    TRACE_X1 = 1'b0,
    TRACE_X2 = 1'b1
  } trace_e;

  typedef struct packed {
    logic [9:0] col;
    logic [8:0] row;
    trace_e     trace;
  } pix_t;

  // full product, drop 16 fraction bits, keep low 18 (wraps)
  function automatic fx_t fx_mul(input fx_t a, input fx_t b);
    logic signed [35:0] p;
    p = a * b;
    return p[33:16];
  endfunction

endpackage

`default_nettype wire

// ==== coeff_loader.sv ====
`default_nettype none

module coeff_loader (
  input  wire                  AnalogClock,
  input  wire                  rst,
  input  osc_pkg::osc_cfg_t    cfg,
  input  wire                  cfg_req,
  output logic                 cfg_ack,
  output osc_pkg::osc_coeff_t  coeff,
  output osc_pkg::osc_state_t  init,
  output logic                 load,
  output logic                 running
);

  typedef enum logic [1:0] {
    IDLE,
    ACK,      // load pulse cycle
    WAIT_LOW  // ack held until host drops req
  } ld_state_e;

  ld_state_e         st;
  osc_pkg::osc_cfg_t cfg_q;

  always_ff @(posedge AnalogClock)
  begin
    if (rst)
    begin
      st      <= IDLE;
      running <= 1'b0;
    end
    else
    begin
      case (st)
        IDLE:
        begin
          if (cfg_req)
          begin
            st      <= ACK;
            running <= 1'b1;  // sticky until reset
          end
        end
        ACK:      st <= WAIT_LOW;
        WAIT_LOW:
        begin
          if (!cfg_req)
            st <= IDLE;
        end
        default:  st <= IDLE;
      endcase
    end
  end

  // capture on accept, held until the next load
  always_ff @(posedge AnalogClock)
  begin
    if (st == IDLE && cfg_req)
      cfg_q <= cfg;
  end

  assign load    = (st == ACK);
  assign cfg_ack = (st != IDLE);
  assign coeff   = cfg_q.coeff;
  assign init    = cfg_q.init;

endmodule

`default_nettype wire

// ==== force_stage.sv ====
`default_nettype none

module force_stage #(
  parameter int TICK_DIV = 32
) (
  input  wire                  AnalogClock,
  input  wire                  rst,
  input  wire                  load,
  input  wire                  running,
  input  osc_pkg::osc_coeff_t  coeff,
  input  osc_pkg::osc_state_t  state,
  output osc_pkg::osc_accel_t  accel,
  output logic                 accel_valid
);

  localparam int CW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [CW-1:0]       cnt;
  logic                tick;
  osc_pkg::fx_t        dx;
  osc_pkg::fx_t        f_mid;
  osc_pkg::osc_accel_t acc_d;

  // cnt is 0 in the cycle after load, tick lands at L+TICK_DIV
  always_ff @(posedge AnalogClock)
  begin
    if (rst || load)
      cnt <= '0;
    else if (running)
    begin
      if (cnt == CW'(TICK_DIV - 1))
        cnt <= '0;
      else
        cnt <= cnt + 1'b1;
    end
  end

  assign tick = running && !load && (cnt == CW'(TICK_DIV - 1));

  always_comb
  begin
    dx    = state.x2 - state.x1;
    f_mid = osc_pkg::fx_mul(coeff.kmid, dx);  // coupling spring
    acc_d.a1 = f_mid
             + osc_pkg::fx_mul(coeff.k1, state.x1)
             + osc_pkg::fx_mul(coeff.g1, state.v1);
    acc_d.a2 = -f_mid
             + osc_pkg::fx_mul(coeff.k2, state.x2)
             + osc_pkg::fx_mul(coeff.g2, state.v2);
  end

  always_ff @(posedge AnalogClock)
  begin
    if (tick)
      accel <= acc_d;
  end

  always_ff @(posedge AnalogClock)
  begin
    if (rst)
      accel_valid <= 1'b0;
    else
      accel_valid <= tick;  // tick already masked by load
  end

endmodule

`default_nettype wire

// ==== euler_stage.sv ====
`default_nettype none

module euler_stage #(
  parameter int DT_SHIFT = 9
) (
  input  wire                  AnalogClock,
  input  wire                  rst,
  input  wire                  load,
  input  osc_pkg::osc_state_t  init,
  input  osc_pkg::osc_accel_t  accel,
  input  wire                  accel_valid,
  output osc_pkg::osc_state_t  state,
  output logic                 state_valid
);

  osc_pkg::osc_state_t nxt;

  // explicit Euler, positions use the old velocities
  always_comb
  begin
    nxt.v1 = state.v1 + (accel.a1 >>> DT_SHIFT);
    nxt.x1 = state.x1 + (state.v1 >>> DT_SHIFT);
    nxt.v2 = state.v2 + (accel.a2 >>> DT_SHIFT);
    nxt.x2 = state.x2 + (state.v2 >>> DT_SHIFT);
  end

  always_ff @(posedge AnalogClock)
  begin
    if (rst)
      state <= '0;
    else if (load)
      state <= init;  // wins over a step in flight
    else if (accel_valid)
      state <= nxt;
  end

  always_ff @(posedge AnalogClock)
  begin
    if (rst)
      state_valid <= 1'b0;
    else
      state_valid <= accel_valid && !load;
  end

endmodule

`default_nettype wire

// ==== trace_plotter.sv ====
`default_nettype none

module trace_plotter #(
  parameter int SCREEN_W = 640,
  parameter int X1_ROW   = 160,
  parameter int X2_ROW   = 480
) (
  input  wire                  AnalogClock,
  input  wire                  rst,
  input  wire                  load,
  input  osc_pkg::osc_state_t  state,
  input  wire                  state_valid,
  output osc_pkg::pix_t        pix,
  output logic                 pix_we
);

  logic [9:0] col;
  logic       x2_due;  // second beat pending

  // baseline plus sign-extended top five bits
  function automatic logic [8:0] row_of(input int base, input osc_pkg::fx_t x);
    logic [8:0] off;
    off = {{4{x[17]}}, x[17:13]};
    return 9'(base) + off;
  endfunction

  // state stays put until the next step, so beat two reads it directly
  always_ff @(posedge AnalogClock)
  begin
    if (rst || load)
    begin
      col    <= '0;
      x2_due <= 1'b0;
      pix_we <= 1'b0;
    end
    else if (state_valid)
    begin
      pix_we <= 1'b1;
      x2_due <= 1'b1;
    end
    else if (x2_due)
    begin
      pix_we <= 1'b1;
      x2_due <= 1'b0;
      if (col == 10'(SCREEN_W - 1))
        col <= '0;
      else
        col <= col + 1'b1;
    end
    else
      pix_we <= 1'b0;
  end

  always_ff @(posedge AnalogClock)
  begin
    if (state_valid)
    begin
      pix.col   <= col;
      pix.row   <= row_of(X1_ROW, state.x1);
      pix.trace <= osc_pkg::TRACE_X1;
    end
    else if (x2_due)
    begin
      pix.col   <= col;  // old column, it advances on this same edge
      pix.row   <= row_of(X2_ROW, state.x2);
      pix.trace <= osc_pkg::TRACE_X2;
    end
  end

endmodule

`default_nettype wire

// ==== eulersillator.sv ====
`default_nettype none

module eulersillator #(
  parameter int TICK_DIV = 32,  // at least 4
  parameter int DT_SHIFT = 9,
  parameter int SCREEN_W = 640,
  parameter int X1_ROW   = 160,
  parameter int X2_ROW   = 480
) (
  input  wire                  AnalogClock,
  input  wire                  rst,
  input  osc_pkg::osc_cfg_t    cfg,
  input  wire                  cfg_req,
  output logic                 cfg_ack,
  output osc_pkg::osc_state_t  state,
  output logic                 state_valid,
  output osc_pkg::pix_t        pix,
  output logic                 pix_we
);

  osc_pkg::osc_coeff_t coeff;
  osc_pkg::osc_state_t init;
  osc_pkg::osc_accel_t accel;
  logic                load;
  logic                running;
  logic                accel_valid;

  coeff_loader u_loader (
    .AnalogClock (AnalogClock),
    .rst         (rst),
    .cfg         (cfg),
    .cfg_req     (cfg_req),
    .cfg_ack     (cfg_ack),
    .coeff       (coeff),
    .init        (init),
    .load        (load),
    .running     (running)
  );

  force_stage #(.TICK_DIV(TICK_DIV)) u_force (
    .AnalogClock (AnalogClock),
    .rst         (rst),
    .load        (load),
    .running     (running),
    .coeff       (coeff),
    .state       (state),       // feedback from the integrator
    .accel       (accel),
    .accel_valid (accel_valid)
  );

  euler_stage #(.DT_SHIFT(DT_SHIFT)) u_euler (
    .AnalogClock (AnalogClock),
    .rst         (rst),
    .load        (load),
    .init        (init),
    .accel       (accel),
    .accel_valid (accel_valid),
    .state       (state),
    .state_valid (state_valid)
  );

  trace_plotter #(
    .SCREEN_W (SCREEN_W),
    .X1_ROW   (X1_ROW),
    .X2_ROW   (X2_ROW)
  ) u_plot (
    .AnalogClock (AnalogClock),
    .rst         (rst),
    .load        (load),
    .state       (state),
    .state_valid (state_valid),
    .pix         (pix),
    .pix_we      (pix_we)
  );

endmodule

`default_nettype wire

// ==== eulersillator_chk.sv ====
`default_nettype none

module eulersillator_chk (
  input wire AnalogClock,
  input wire rst,
  input wire load,
  input wire cfg_req,
  input wire cfg_ack,
  input wire accel_valid,
  input wire state_valid,
  input wire pix_we
);

  int fail_count = 0;  // bumped by every failing assertion

  // host still holds req when ack comes up
  ack_after_req: assert property (@(posedge AnalogClock) disable iff (rst)
    $rose(cfg_ack) |-> cfg_req)
    else
    begin
      $error("cfg_ack rose while cfg_req was low");
      fail_count++;
    end

  sv_after_av: assert property (@(posedge AnalogClock) disable iff (rst || load)
    accel_valid |=> state_valid)
    else
    begin
      $error("state_valid did not follow accel_valid by one cycle");
      fail_count++;
    end

  // x1 beat then x2 beat unless a load cancels them
  two_beats: assert property (@(posedge AnalogClock) disable iff (rst || load)
    state_valid |=> pix_we ##1 pix_we)
    else
    begin
      $error("pixel writes missing after state_valid");
      fail_count++;
    end

  no_stray_we: assert property (@(posedge AnalogClock) disable iff (rst)
    pix_we |-> $past(state_valid) || $past(state_valid, 2))
    else
    begin
      $error("pixel write without a recent state_valid");
      fail_count++;
    end

endmodule

bind eulersillator eulersillator_chk u_chk (
  .AnalogClock (AnalogClock),
  .rst         (rst),
  .load        (load),
  .cfg_req     (cfg_req),
  .cfg_ack     (cfg_ack),
  .accel_valid (accel_valid),
  .state_valid (state_valid),
  .pix_we      (pix_we)
);

`default_nettype wire

// ==== tb_eulersillator.sv ====
`default_nettype none

module tb_eulersillator;

  localparam int TICK_DIV = 8;
  localparam int DT_SHIFT = 9;
  localparam int SCREEN_W = 24;
  localparam int X1_ROW   = 160;
  localparam int X2_ROW   = 480;

  logic                AnalogClock = 1'b0;
  logic                rst;
  osc_pkg::osc_cfg_t   cfg;
  logic                cfg_req;
  logic                cfg_ack;
  osc_pkg::osc_state_t state;
  logic                state_valid;
  osc_pkg::pix_t       pix;
  logic                pix_we;

  osc_pkg::osc_cfg_t   m_cfg;    // config the model runs on
  osc_pkg::osc_state_t m_state;
  int                  m_col;
  int                  loads_sent = 0;
  int                  loads_seen = 0;

  eulersillator #(.TICK_DIV(TICK_DIV), .SCREEN_W(SCREEN_W)) UUT (.*);

  always #10 AnalogClock = ~AnalogClock;

  always @(negedge AnalogClock)
    if (UUT.load)
      loads_seen <= loads_seen + 1;  // load is settled by mid-cycle

  // any failing assertion in the bound checker
  always @(UUT.u_chk.fail_count)
    if (UUT.u_chk.fail_count != 0)
      fail_with("an assertion in the bound checker failed");

  task automatic stop_run();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic fail_with(input string what);
    $display("%s at time %0t", what, $time);
    stop_run();
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp)
    begin
      $display("Error: time %0t %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_state(input osc_pkg::osc_state_t got,
                             input osc_pkg::osc_state_t exp, input string name);
    if (got !== exp)
    begin
      $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_pix(input osc_pkg::pix_t got, input osc_pkg::pix_t exp,
                           input string name);
    if (got !== exp)
    begin
      $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  // floored q16 product keeping the low 18 bits
  function automatic osc_pkg::fx_t mul_q16(input osc_pkg::fx_t a, input osc_pkg::fx_t b);
    longint p;
    p = longint'(a) * longint'(b);
    p = p >>> 16;
    return p[17:0];
  endfunction

  function automatic osc_pkg::osc_state_t euler_next(input osc_pkg::osc_coeff_t c,
                                                      input osc_pkg::osc_state_t s);
    osc_pkg::fx_t        fm;
    osc_pkg::fx_t        a1;
    osc_pkg::fx_t        a2;
    osc_pkg::osc_state_t n;
    fm = mul_q16(c.kmid, s.x2 - s.x1);
    a1 = fm + mul_q16(c.k1, s.x1) + mul_q16(c.g1, s.v1);
    a2 = -fm + mul_q16(c.k2, s.x2) + mul_q16(c.g2, s.v2);
    n.v1 = s.v1 + (a1 >>> DT_SHIFT);
    n.x1 = s.x1 + (s.v1 >>> DT_SHIFT);  // old velocity
    n.v2 = s.v2 + (a2 >>> DT_SHIFT);
    n.x2 = s.x2 + (s.v2 >>> DT_SHIFT);
    return n;
  endfunction

  function automatic logic [8:0] row_for(input int base, input osc_pkg::fx_t x);
    int off;
    off = $signed(x[17:13]);
    return 9'(base + off);
  endfunction

  function automatic osc_pkg::fx_t rand_fx(input int span);
    int r;
    r = $urandom_range(2 * span) - span;
    return r[17:0];
  endfunction

  function automatic osc_pkg::osc_cfg_t rand_cfg();
    osc_pkg::osc_cfg_t c;
    c.coeff.k1   = rand_fx(32768);
    c.coeff.kmid = rand_fx(32768);
    c.coeff.k2   = rand_fx(32768);
    c.coeff.g1   = rand_fx(8192);
    c.coeff.g2   = rand_fx(8192);
    c.init.x1    = rand_fx(65535);
    c.init.v1    = rand_fx(16384);
    c.init.x2    = rand_fx(65535);
    c.init.v2    = rand_fx(16384);
    return c;
  endfunction

  task automatic next_cycle();
    @(posedge AnalogClock);
    #2;
  endtask

  task automatic load_cfg(input osc_pkg::osc_cfg_t c);
    int n;
    cfg        = c;
    cfg_req    = 1'b1;
    m_cfg      = c;
    m_state    = c.init;
    m_col      = 0;
    loads_sent = loads_sent + 1;
    n = 0;
    while (!cfg_ack)
    begin
      next_cycle();
      n++;
      if (n > 10)
        fail_with("cfg_ack never rose after cfg_req");
    end
    next_cycle();
    check_state(state, m_state, "state");  // init lands one cycle after load
    check_bit(pix_we, 1'b0, "pix_we");
    check_bit(cfg_ack, 1'b1, "cfg_ack");
    cfg_req = 1'b0;
    n = 0;
    while (cfg_ack)
    begin
      next_cycle();
      n++;
      if (n > 10)
        fail_with("cfg_ack stayed high after cfg_req dropped");
    end
    check_bit(pix_we, 1'b0, "pix_we");  // still no stale beat
    if (loads_seen != loads_sent)
      fail_with("a configuration was not accepted exactly once");
  endtask

  task automatic expect_pix(input osc_pkg::trace_e tr, input int base,
                            input osc_pkg::fx_t x);
    osc_pkg::pix_t exp;
    exp.col   = 10'(m_col);
    exp.row   = row_for(base, x);
    exp.trace = tr;
    next_cycle();
    check_bit(pix_we, 1'b1, "pix_we");
    check_pix(pix, exp, "pix");
  endtask

  task automatic run_steps(input int steps);
    int s;
    int n;
    for (s = 0; s < steps; s++)
    begin
      m_state = euler_next(m_cfg.coeff, m_state);
      n = 0;
      next_cycle();
      while (!state_valid)
      begin
        check_bit(pix_we, 1'b0, "pix_we");  // nothing between steps
        n++;
        if (n > 4 * TICK_DIV)
          fail_with("state_valid did not arrive");
        next_cycle();
      end
      check_state(state, m_state, "state");
      expect_pix(osc_pkg::TRACE_X1, X1_ROW, m_state.x1);
      expect_pix(osc_pkg::TRACE_X2, X2_ROW, m_state.x2);
      m_col = (m_col + 1) % SCREEN_W;
    end
  endtask

  initial
  begin
    void'($urandom(8629));
    rst     = 1'b1;
    cfg     = '0;
    cfg_req = 1'b0;
    m_col   = 0;
    repeat (2) next_cycle();
    rst = 1'b0;
    check_state(state, '0, "state");
    repeat (20)
    begin
      next_cycle();
      check_bit(cfg_ack, 1'b0, "cfg_ack");
      check_bit(state_valid, 1'b0, "state_valid");
      check_bit(pix_we, 1'b0, "pix_we");
    end
    load_cfg(rand_cfg());
    run_steps(60);
    // reload lands somewhere inside the next step
    repeat ($urandom_range(7)) next_cycle();
    load_cfg(rand_cfg());
    run_steps(30);
    repeat (10)
    begin
      repeat ($urandom_range(7)) next_cycle();
      load_cfg(rand_cfg());
      run_steps(30);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== eulersillator.f ====
osc_pkg.sv
coeff_loader.sv
force_stage.sv
euler_stage.sv
trace_plotter.sv
eulersillator.sv
eulersillator_chk.sv
tb_eulersillator.sv
